/* src.f */
+incdir+.
secp_pkg.sv
sig_reg_file.sv
mod_bin_inv.sv
sig_reply_tx.sv
sig_verify_ctrl.sv
secp_verify_top.sv
secp_verify_props.sv
tb_secp_verify.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_secp_verify -o tb_secp_verify
out=$(./obj_dir/tb_secp_verify || true)
echo "$out"
# The run passes only if the testbench printed its pass line
echo "$out" | grep -q "All tests passed!"

/* tb_secp_verify.sv */
`timescale 1ns/1ps
`include "secp_defines.svh"

module tb_secp_verify;
  import secp_pkg::*;

  // Eight verify commands of up to about 1100 cycles each, plus 125 debug reads
  localparam int MAX_CYCLES = 20000;
  localparam int LAST_REG   = `SECP_REG_W + 3;
  localparam int PICK_RAND  = 0;
  localparam int PICK_N     = 1;
  localparam int PICK_ZERO  = 2;
  localparam int PICK_OVER  = 3;

  logic         i_clk = 1'b0;
  logic         i_rst;
  stream_beat_t i_cmd;
  logic         i_cmd_val;
  logic         o_cmd_rdy;
  stream_beat_t o_tx;
  logic         o_tx_val;
  logic         i_tx_rdy;
  logic         i_mm_rd;
  logic [15:0]  i_mm_addr;
  word_t        o_mm_rd_dat;
  logic         o_mm_rd_dat_val;

  integer seed       = 32'h219;
  integer rdy_seed   = 32'h219;
  int     errors     = 0;
  int     rpl_errors = 0;
  int     cycles     = 0;
  int     rx_idx     = 0;
  logic   gaps_on    = 1'b0;
  logic   stall_on   = 1'b0;
  string  test_name  = "reset";
  word_t  exp_words[$];
  word_t  exp_mem [0:LAST_REG];

  secp_verify_top secp_verify_top_i (
    .i_clk           ( i_clk           ),
    .i_rst           ( i_rst           ),
    .i_cmd           ( i_cmd           ),
    .i_cmd_val       ( i_cmd_val       ),
    .o_cmd_rdy       ( o_cmd_rdy       ),
    .o_tx            ( o_tx            ),
    .o_tx_val        ( o_tx_val        ),
    .i_tx_rdy        ( i_tx_rdy        ),
    .i_mm_rd         ( i_mm_rd         ),
    .i_mm_addr       ( i_mm_addr       ),
    .o_mm_rd_dat     ( o_mm_rd_dat     ),
    .o_mm_rd_dat_val ( o_mm_rd_dat_val )
  );

  always #50 i_clk = ~i_clk;

  // Group order n of secp256k1
  function automatic u256_t order_n();
    return 256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;
  endfunction

  // Extended Euclid with the coefficients kept modulo n
  function automatic u256_t ref_inverse(input u256_t a);
    logic [511:0] r0, r1, t0, t1, q, tmp, prod, n;
    n  = {256'd0, order_n()};
    r0 = n;
    r1 = {256'd0, a};
    t0 = '0;
    t1 = 512'd1;
    while (r1 != '0) begin
      q    = r0 / r1;
      tmp  = r0 - q * r1;
      r0   = r1;
      r1   = tmp;
      prod = (q * t1) % n;
      tmp  = (t0 >= prod) ? (t0 - prod) : (t0 + n - prod);
      t0   = t1;
      t1   = tmp;
    end
    return t0[255:0];
  endfunction

  // Reply words in beat order, header in the low word
  function automatic logic [191:0] build_reply(input word_t index, input u256_t s, input u256_t r);
    logic  s_bad, r_bad;
    word_t hdr;
    s_bad = (s == '0) || (s >= order_n());
    r_bad = (r == '0) || (r >= order_n());
    hdr   = {32'd24, 16'h0000, `SECP_CMD_VERIFY_RPL};
    return {{62'd0, s_bad, r_bad}, index, hdr};
  endfunction

  function automatic u256_t rand_u256();
    u256_t v;
    for (int i = 0; i < 8; i++) begin
      v[i*32 +: 32] = $random(seed);
    end
    return v;
  endfunction

  function automatic u256_t pick_value(input int sel);
    u256_t v;
    v      = rand_u256();
    v[255] = 1'b0;
    case (sel)
      PICK_N:    v = order_n();
      PICK_ZERO: v = '0;
      PICK_OVER: v = order_n() + 256'd5;
      default:   v = (v == '0) ? 256'd7 : v;
    endcase
    return v;
  endfunction

  task automatic send_beat(input word_t dat, input logic sop, input logic eop);
    int gap;
    gap = gaps_on ? ($random(seed) & 3) : 0;
    repeat (gap) begin
      @(posedge i_clk);
      #1;
    end
    i_cmd     = '{dat: dat, sop: sop, eop: eop};
    i_cmd_val = 1'b1;
    @(negedge i_clk);
    while (!o_cmd_rdy) @(negedge i_clk);
    @(posedge i_clk);
    #1;
    i_cmd_val = 1'b0;
  endtask

  task automatic run_verify(input string name, input word_t index, input int s_sel,
                            input int r_sel);
    u256_t        s, r, hash, qx, qy, w;
    logic [191:0] rpl;
    word_t        words [0:`SECP_SIG_WORDS-1];
    s         = pick_value(s_sel);
    r         = pick_value(r_sel);
    hash      = rand_u256();
    qx        = rand_u256();
    qy        = rand_u256();
    test_name = name;
    rpl       = build_reply(index, s, r);
    // Bit 129 is the out_of_range_s flag
    w         = rpl[129] ? '0 : ref_inverse(s);
    for (int i = 0; i < 4; i++) begin
      words[i]      = s[i*64 +: 64];
      words[i + 4]  = r[i*64 +: 64];
      words[i + 8]  = hash[i*64 +: 64];
      words[i + 12] = qx[i*64 +: 64];
      words[i + 16] = qy[i*64 +: 64];
      exp_mem[`SECP_REG_W + i] = w[i*64 +: 64];
    end
    exp_mem[`SECP_REG_CURR_CMD] = {32'd168, 16'h0000, `SECP_CMD_VERIFY};
    for (int i = 0; i < `SECP_SIG_WORDS; i++) begin
      exp_mem[`SECP_REG_S + i] = words[i];
    end
    for (int i = 0; i < 3; i++) begin
      exp_words.push_back(rpl[i*64 +: 64]);
    end
    send_beat(exp_mem[`SECP_REG_CURR_CMD], 1'b1, 1'b0);
    send_beat(index, 1'b0, 1'b0);
    for (int i = 0; i < `SECP_SIG_WORDS; i++) begin
      send_beat(words[i], 1'b0, i == `SECP_SIG_WORDS - 1);
    end
    while (rx_idx != exp_words.size()) @(negedge i_clk);
    @(posedge i_clk);
    #1;
  endtask

  task automatic run_ignore(input string name);
    test_name = name;
    send_beat({32'd24, 16'h0000, 16'h0777}, 1'b1, 1'b0);
    for (int i = 0; i < 3; i++) begin
      send_beat({$random(seed), $random(seed)}, 1'b0, i == 2);
    end
  endtask

  task automatic check_regs(input string name);
    word_t got;
    for (int k = 0; k <= LAST_REG; k++) begin
      i_mm_addr = 16'(k * 8);
      i_mm_rd   = 1'b1;
      @(posedge i_clk);
      #1;
      i_mm_rd = 1'b0;
      @(negedge i_clk);
      while (!o_mm_rd_dat_val) @(negedge i_clk);
      got = o_mm_rd_dat;
      assert (got === exp_mem[k]) else begin
        errors++;
        $display("ERR %s reg %0d expected %h actual %h", name, k, exp_mem[k], got);
      end
      @(posedge i_clk);
      #1;
    end
  endtask

  // Reply beats are compared in arrival order
  always @(negedge i_clk) begin
    if (!i_rst && o_tx_val && i_tx_rdy) begin
      if (rx_idx >= exp_words.size()) begin
        rpl_errors++;
        $display("Reply beat arrived with no reply expected during test %s", test_name);
      end else begin
        assert (o_tx.dat === exp_words[rx_idx]) else begin
          rpl_errors++;
          $display("ERR %s beat %0d expected %h actual %h", test_name, rx_idx % 3,
                   exp_words[rx_idx], o_tx.dat);
        end
        assert (o_tx.sop === (rx_idx % 3 == 0) && o_tx.eop === (rx_idx % 3 == 2)) else begin
          rpl_errors++;
          $display("ERR %s beat %0d sop/eop expected %b%b actual %b%b", test_name, rx_idx % 3,
                   rx_idx % 3 == 0, rx_idx % 3 == 2, o_tx.sop, o_tx.eop);
        end
        rx_idx++;
      end
    end
  end

  initial begin
    i_tx_rdy = 1'b1;
    forever begin
      @(posedge i_clk);
      #1;
      i_tx_rdy = stall_on ? (($random(rdy_seed) & 3) != 0) : 1'b1;
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles in test %s", cycles, test_name);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    i_rst     = 1'b1;
    i_cmd     = '0;
    i_cmd_val = 1'b0;
    i_mm_rd   = 1'b0;
    i_mm_addr = '0;
    repeat (10) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    run_verify("basic", 64'h0000_0001_A5A5_0011, PICK_RAND, PICK_RAND);
    check_regs("basic_regs");
    run_verify("s_eq_n", 64'h0000_0002_A5A5_0022, PICK_N, PICK_RAND);
    check_regs("s_eq_n_regs");
    run_verify("s_zero", 64'h0000_0003_A5A5_0033, PICK_ZERO, PICK_RAND);
    check_regs("s_zero_regs");
    run_verify("r_ge_n", 64'h0000_0004_A5A5_0044, PICK_RAND, PICK_OVER);
    check_regs("r_ge_n_regs");
    run_ignore("unknown_cmd");
    run_verify("after_unknown", 64'h0000_0005_A5A5_0055, PICK_RAND, PICK_RAND);
    check_regs("after_unknown_regs");
    // Gaps on the command stream and back-pressure on the reply
    gaps_on  = 1'b1;
    stall_on = 1'b1;
    run_verify("stall_basic", 64'h0000_0006_A5A5_0066, PICK_RAND, PICK_RAND);
    run_verify("stall_s_zero", 64'h0000_0007_A5A5_0077, PICK_ZERO, PICK_RAND);
    run_verify("stall_r_eq_n", 64'h0000_0008_A5A5_0088, PICK_RAND, PICK_N);
    $display("Errors: %0d register, %0d reply, %0d replies received",
             errors, rpl_errors, rx_idx / 3);
    if (errors + rpl_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* secp_verify_props.sv */
`timescale 1ns/1ps

module secp_verify_props (
  input logic                   i_clk,
  input logic                   i_rst,
  input logic                   o_cmd_rdy,
  input secp_pkg::stream_beat_t o_tx,
  input logic                   o_tx_val,
  input logic                   i_tx_rdy,
  input logic                   i_mm_rd,
  input logic                   o_mm_rd_dat_val
);

  // A stalled reply beat holds until it transfers
  assert property (@(posedge i_clk) disable iff (i_rst)
    (o_tx_val && !i_tx_rdy) |=> (o_tx_val && $stable(o_tx)))
    else $error("Reply beat changed or dropped while stalled");

  // Debug read data is valid exactly two cycles after the strobe
  assert property (@(posedge i_clk) disable iff (i_rst)
    o_mm_rd_dat_val == $past(i_mm_rd, 2))
    else $error("Debug read valid not two cycles after the read strobe");

  assert property (@(posedge i_clk) i_rst |=> (!o_tx_val && !o_cmd_rdy))
    else $error("Reply valid or command ready high right after reset");

endmodule

bind secp_verify_top secp_verify_props secp_verify_props_i (
  .i_clk           ( i_clk           ),
  .i_rst           ( i_rst           ),
  .o_cmd_rdy       ( o_cmd_rdy       ),
  .o_tx            ( o_tx            ),
  .o_tx_val        ( o_tx_val        ),
  .i_tx_rdy        ( i_tx_rdy        ),
  .i_mm_rd         ( i_mm_rd         ),
  .o_mm_rd_dat_val ( o_mm_rd_dat_val )
);

/* secp_verify_top.sv */
`timescale 1ns/1ps

module secp_verify_top (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  secp_pkg::stream_beat_t i_cmd,
  input  logic                   i_cmd_val,
  output logic                   o_cmd_rdy,
  output secp_pkg::stream_beat_t o_tx,
  output logic                   o_tx_val,
  input  logic                   i_tx_rdy,
  input  logic                   i_mm_rd,
  input  logic [15:0]            i_mm_addr,
  output secp_pkg::word_t        o_mm_rd_dat,
  output logic                   o_mm_rd_dat_val
);
  import secp_pkg::*;

  u256_t      inv_in_dat, inv_out_dat;
  logic       inv_in_val, inv_in_rdy, inv_out_val, inv_out_rdy;
  logic       wr_en;
  reg_addr_t  wr_addr;
  word_t      wr_dat;
  logic       rpl_start, rpl_busy;
  ver_reply_t rpl;

  sig_verify_ctrl sig_verify_ctrl_i (
    .i_clk       ( i_clk       ),
    .i_rst       ( i_rst       ),
    .i_cmd       ( i_cmd       ),
    .i_cmd_val   ( i_cmd_val   ),
    .o_cmd_rdy   ( o_cmd_rdy   ),
    .o_inv_dat   ( inv_in_dat  ),
    .o_inv_val   ( inv_in_val  ),
    .i_inv_rdy   ( inv_in_rdy  ),
    .i_inv_dat   ( inv_out_dat ),
    .i_inv_val   ( inv_out_val ),
    .o_inv_rdy   ( inv_out_rdy ),
    .o_wr_en     ( wr_en       ),
    .o_wr_addr   ( wr_addr     ),
    .o_wr_dat    ( wr_dat      ),
    .o_rpl_start ( rpl_start   ),
    .o_rpl       ( rpl         ),
    .i_rpl_busy  ( rpl_busy    )
  );

  // Inverse of s modulo the group order
  mod_bin_inv mod_bin_inv_i (
    .i_clk ( i_clk       ),
    .i_rst ( i_rst       ),
    .i_dat ( inv_in_dat  ),
    .i_val ( inv_in_val  ),
    .o_rdy ( inv_in_rdy  ),
    .o_dat ( inv_out_dat ),
    .o_val ( inv_out_val ),
    .i_rdy ( inv_out_rdy )
  );

  sig_reg_file sig_reg_file_i (
    .i_clk           ( i_clk           ),
    .i_rst           ( i_rst           ),
    .i_wr_en         ( wr_en           ),
    .i_wr_addr       ( wr_addr         ),
    .i_wr_dat        ( wr_dat          ),
    .i_mm_rd         ( i_mm_rd         ),
    .i_mm_addr       ( i_mm_addr       ),
    .o_mm_rd_dat     ( o_mm_rd_dat     ),
    .o_mm_rd_dat_val ( o_mm_rd_dat_val )
  );

  sig_reply_tx sig_reply_tx_i (
    .i_clk    ( i_clk     ),
    .i_rst    ( i_rst     ),
    .i_start  ( rpl_start ),
    .i_rpl    ( rpl       ),
    .o_busy   ( rpl_busy  ),
    .o_tx     ( o_tx      ),
    .o_tx_val ( o_tx_val  ),
    .i_tx_rdy ( i_tx_rdy  )
  );

endmodule

/* sig_verify_ctrl.sv */
`timescale 1ns/1ps
`include "secp_defines.svh"

module sig_verify_ctrl (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  secp_pkg::stream_beat_t i_cmd,
  input  logic                   i_cmd_val,
  output logic                   o_cmd_rdy,
  output secp_pkg::u256_t        o_inv_dat,
  output logic                   o_inv_val,
  input  logic                   i_inv_rdy,
  input  secp_pkg::u256_t        i_inv_dat,
  input  logic                   i_inv_val,
  output logic                   o_inv_rdy,
  output logic                   o_wr_en,
  output secp_pkg::reg_addr_t    o_wr_addr,
  output secp_pkg::word_t        o_wr_dat,
  output logic                   o_rpl_start,
  output secp_pkg::ver_reply_t   o_rpl,
  input  logic                   i_rpl_busy
);
  import secp_pkg::*;

  ctrl_state_t state, state_nxt;
  cmd_header_t hdr;
  logic [4:0]  cnt;
  logic [1:0]  wcnt;
  reg_addr_t   word_addr;
  u256_t       s, r, w;
  word_t       index_q;
  ver_flags_t  flags_q;
  logic        cmd_acc, inv_acc, last_word, s_bad, r_bad;

  assign hdr       = i_cmd.dat;
  assign cmd_acc   = i_cmd_val && o_cmd_rdy;
  assign o_inv_rdy = (state == CALC_S_INV);
  assign inv_acc   = i_inv_val && o_inv_rdy;
  assign last_word = (cnt == 5'(`SECP_SIG_WORDS - 1));
  // Zero is rejected too, the inverter never ends on it
  assign s_bad     = (s == '0) || (s >= SECP_N);
  assign r_bad     = (r == '0) || (r >= SECP_N);
  assign o_inv_dat = s;
  assign o_rpl     = '{index: index_q, flags: flags_q};

  // Payload word position in the register map
  always_comb begin
    if (cnt < 5'd4) begin
      word_addr = reg_addr_t'(`SECP_REG_S) + reg_addr_t'(cnt[1:0]);
    end else if (cnt < 5'd8) begin
      word_addr = reg_addr_t'(`SECP_REG_R) + reg_addr_t'(cnt[1:0]);
    end else if (cnt < 5'd12) begin
      word_addr = reg_addr_t'(`SECP_REG_HASH) + reg_addr_t'(cnt[1:0]);
    end else begin
      word_addr = reg_addr_t'(`SECP_REG_Q) + reg_addr_t'(cnt - 5'd12);
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (cmd_acc && hdr.cmd == `SECP_CMD_VERIFY) begin
          state_nxt = GET_INDEX;
        end else if (cmd_acc && !i_cmd.eop) begin
          state_nxt = IGNORE;
        end
      end
      GET_INDEX:  if (cmd_acc) state_nxt = PARSE;
      PARSE:      if (cmd_acc && last_word) state_nxt = CALC_S_INV;
      // Bad s skips the inverter and w is written as zero
      CALC_S_INV: if (flags_q.out_of_range_s || inv_acc) state_nxt = WRITE_W;
      WRITE_W:    if (wcnt == 2'd3) state_nxt = REPLY;
      REPLY:      if (!o_rpl_start && !i_rpl_busy) state_nxt = IDLE;
      IGNORE:     if (cmd_acc && i_cmd.eop) state_nxt = IDLE;
      default:    state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= IDLE;
      o_cmd_rdy   <= 1'b0;
      o_inv_val   <= 1'b0;
      o_wr_en     <= 1'b0;
      o_rpl_start <= 1'b0;
      cnt         <= '0;
      wcnt        <= '0;
    end else begin
      state       <= state_nxt;
      o_cmd_rdy   <= (state_nxt inside {IDLE, GET_INDEX, PARSE, IGNORE});
      o_wr_en     <= 1'b0;
      o_rpl_start <= 1'b0;
      if (o_inv_val && i_inv_rdy) begin
        o_inv_val <= 1'b0;
      end
      case (state)
        IDLE: begin
          cnt <= '0;
          if (cmd_acc && hdr.cmd == `SECP_CMD_VERIFY) begin
            o_wr_en <= 1'b1;
          end
        end
        PARSE: begin
          if (cmd_acc) begin
            o_wr_en <= 1'b1;
            cnt     <= cnt + 5'd1;
            if (last_word) begin
              o_inv_val <= !s_bad;
            end
          end
        end
        CALC_S_INV: wcnt <= '0;
        WRITE_W: begin
          o_wr_en <= 1'b1;
          wcnt    <= wcnt + 2'd1;
          if (wcnt == 2'd3) begin
            o_rpl_start <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    case (state)
      IDLE: begin
        o_wr_addr <= reg_addr_t'(`SECP_REG_CURR_CMD);
        o_wr_dat  <= i_cmd.dat;
      end
      GET_INDEX: begin
        if (cmd_acc) begin
          index_q <= i_cmd.dat;
        end
      end
      PARSE: begin
        o_wr_addr <= word_addr;
        o_wr_dat  <= i_cmd.dat;
        // Least significant word first
        if (cmd_acc && cnt < 5'd4) begin
          s[cnt[1:0]*64 +: 64] <= i_cmd.dat;
        end
        if (cmd_acc && cnt >= 5'd4 && cnt < 5'd8) begin
          r[cnt[1:0]*64 +: 64] <= i_cmd.dat;
        end
        if (cmd_acc && last_word) begin
          flags_q <= '{out_of_range_s: s_bad, out_of_range_r: r_bad};
        end
      end
      CALC_S_INV: begin
        if (flags_q.out_of_range_s) begin
          w <= '0;
        end else if (inv_acc) begin
          w <= i_inv_dat;
        end
      end
      WRITE_W: begin
        o_wr_addr <= reg_addr_t'(`SECP_REG_W) + reg_addr_t'(wcnt);
        o_wr_dat  <= w[wcnt*64 +: 64];
      end
      default: ;
    endcase
  end

endmodule

/* sig_reply_tx.sv */
`timescale 1ns/1ps
`include "secp_defines.svh"

module sig_reply_tx (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_start,
  input  secp_pkg::ver_reply_t   i_rpl,
  output logic                   o_busy,
  output secp_pkg::stream_beat_t o_tx,
  output logic                   o_tx_val,
  input  logic                   i_tx_rdy
);
  import secp_pkg::*;

  localparam logic [1:0] LAST_BEAT = 2'(`SECP_RPL_BEATS - 1);

  ver_reply_t  rpl_q;
  cmd_header_t hdr;
  logic [1:0]  beat_cnt;

  assign o_busy = o_tx_val;

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      rpl_q <= i_rpl;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_tx_val <= 1'b0;
      beat_cnt <= '0;
    end else if (i_start) begin
      o_tx_val <= 1'b1;
      beat_cnt <= '0;
    end else if (o_tx_val && i_tx_rdy) begin
      if (beat_cnt == LAST_BEAT) begin
        o_tx_val <= 1'b0;
      end else begin
        beat_cnt <= beat_cnt + 2'd1;
      end
    end
  end

  // Beat content follows the counter, so it holds while stalled
  always_comb begin
    hdr      = '0;
    hdr.cmd  = `SECP_CMD_VERIFY_RPL;
    hdr.len  = 32'(`SECP_RPL_BEATS * 8);
    o_tx     = '0;
    o_tx.sop = (beat_cnt == 2'd0);
    o_tx.eop = (beat_cnt == LAST_BEAT);
    case (beat_cnt)
      2'd0:    o_tx.dat = hdr;
      2'd1:    o_tx.dat = rpl_q.index;
      default: o_tx.dat = word_t'(rpl_q.flags);
    endcase
  end

endmodule

/* mod_bin_inv.sv */
`timescale 1ns/1ps

module mod_bin_inv (
  input  logic            i_clk,
  input  logic            i_rst,
  input  secp_pkg::u256_t i_dat,
  input  logic            i_val,
  output logic            o_rdy,
  output secp_pkg::u256_t o_dat,
  output logic            o_val,
  input  logic            i_rdy
);
  import secp_pkg::*;

  u256_t u, v, x1, x2;
  logic  busy;
  logic  finish;

  // x/2 mod n, adding n first when x is odd
  function automatic u256_t half_mod(input u256_t x);
    logic [256:0] sum;
    sum = {1'b0, x} + (x[0] ? {1'b0, SECP_N} : 257'd0);
    return sum[256:1];
  endfunction

  function automatic u256_t sub_mod(input u256_t a, input u256_t b);
    return (a >= b) ? (a - b) : (a - b + SECP_N);
  endfunction

  // New work only while idle and no result is waiting
  assign o_rdy  = !busy && !o_val;
  assign finish = busy && ((u == 256'd1) || (v == 256'd1));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy  <= 1'b0;
      o_val <= 1'b0;
    end else begin
      if (o_val && i_rdy) begin
        o_val <= 1'b0;
      end
      if (i_val && o_rdy) begin
        busy <= 1'b1;
      end else if (finish) begin
        busy  <= 1'b0;
        o_val <= 1'b1;
      end
    end
  end

  // One halving or one subtraction per cycle
  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      u  <= i_dat;
      v  <= SECP_N;
      x1 <= 256'd1;
      x2 <= '0;
    end else if (busy) begin
      if (u == 256'd1) begin
        o_dat <= x1;
      end else if (v == 256'd1) begin
        o_dat <= x2;
      end else if (!u[0]) begin
        u  <= u >> 1;
        x1 <= half_mod(x1);
      end else if (!v[0]) begin
        v  <= v >> 1;
        x2 <= half_mod(x2);
      end else if (u >= v) begin
        u  <= u - v;
        x1 <= sub_mod(x1, x2);
      end else begin
        v  <= v - u;
        x2 <= sub_mod(x2, x1);
      end
    end
  end

endmodule

/* sig_reg_file.sv */
`timescale 1ns/1ps
`include "secp_defines.svh"

module sig_reg_file (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_wr_en,
  input  secp_pkg::reg_addr_t i_wr_addr,
  input  secp_pkg::word_t     i_wr_dat,
  input  logic                i_mm_rd,
  input  logic [15:0]         i_mm_addr,
  output secp_pkg::word_t     o_mm_rd_dat,
  output logic                o_mm_rd_dat_val
);
  import secp_pkg::*;

  word_t     mem [0:`SECP_REG_DEPTH-1];
  reg_addr_t rd_addr;
  logic      rd_pend;

  // Controller write port
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_dat;
    end
  end

  // Debug read, byte address to word address, then registered data
  always_ff @(posedge i_clk) begin
    rd_addr     <= reg_addr_t'(i_mm_addr >> 3);
    o_mm_rd_dat <= mem[rd_addr];
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rd_pend         <= 1'b0;
      o_mm_rd_dat_val <= 1'b0;
    end else begin
      rd_pend         <= i_mm_rd;
      o_mm_rd_dat_val <= rd_pend;
    end
  end

endmodule

/* secp_pkg.sv */
package secp_pkg;

  typedef logic [63:0]  word_t;
  typedef logic [255:0] u256_t;
  typedef logic [4:0]   reg_addr_t;

  // Group order n of secp256k1
  localparam u256_t SECP_N =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

  typedef struct packed {
    logic [31:0] len;
    logic [15:0] rsvd;
    logic [15:0] cmd;
  } cmd_header_t;

  // Valid and ready travel beside the beat
  typedef struct packed {
    word_t dat;
    logic  sop;
    logic  eop;
  } stream_beat_t;

  typedef struct packed {
    logic out_of_range_s;
    logic out_of_range_r;
  } ver_flags_t;

  typedef struct packed {
    word_t      index;
    ver_flags_t flags;
  } ver_reply_t;

  typedef enum logic [2:0] {
    IDLE,
    GET_INDEX,
    PARSE,
    CALC_S_INV,
    WRITE_W,
    REPLY,
    IGNORE
  } ctrl_state_t;

endpackage

/* secp_defines.svh */
`ifndef SECP_DEFINES_SVH
`define SECP_DEFINES_SVH

// Command codes in the header cmd field
`define SECP_CMD_VERIFY     16'h0200
`define SECP_CMD_VERIFY_RPL 16'h0201

// Register map, word addresses
`define SECP_REG_CURR_CMD 0
`define SECP_REG_S        1
`define SECP_REG_R        5
`define SECP_REG_HASH     9
`define SECP_REG_Q        13
`define SECP_REG_W        21

`define SECP_REG_DEPTH 32

// Payload words after the index: s, r, hash and Q (x then y)
`define SECP_SIG_WORDS 20
`define SECP_RPL_BEATS 3

`endif
